//--- test_mem_macros.svh
`ifndef TEST_MEM_MACROS_SVH
`define TEST_MEM_MACROS_SVH

// Data word carried by the RAM and both FIFOs
`define TM_DATA_WIDTH 32

// Transfer counts and FIFO sizes
`define TM_COUNT_WIDTH 24

// Default RAM address width
`define TM_ADDR_WIDTH 8

// Default address width of one ping-pong buffer
`define TM_FIFO_AW 4

`endif

//--- test_mem_pkg.sv
`include "test_mem_macros.svh"

package test_mem_pkg;

  // One data word
  typedef logic [`TM_DATA_WIDTH-1:0] data_word_t;

  // Word counts for transfers and FIFO buffers
  typedef logic [`TM_COUNT_WIDTH-1:0] xfer_count_t;

  // Transfer command, one per direction
  // Only the low address bits reach the RAM
  typedef struct packed {
    logic [63:0] addr;
    xfer_count_t count;
    logic        inc;
    logic        dec;
  } xfer_cmd_t;

  // Direct random access request
  typedef struct packed {
    logic        en;
    logic        we;
    logic [63:0] address;
    data_word_t  wdata;
  } bram_req_t;

endpackage

//--- blk_mem.sv
`timescale 1ns/10ps
`include "test_mem_macros.svh"

module blk_mem #(
  parameter int DATA_WIDTH    = `TM_DATA_WIDTH,
  parameter int ADDRESS_WIDTH = `TM_ADDR_WIDTH
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [ADDRESS_WIDTH-1:0] wr_addr,
  input  logic [ADDRESS_WIDTH-1:0] rd_addr,
  input  logic [DATA_WIDTH-1:0]    wdata,
  output logic [DATA_WIDTH-1:0]    rdata
);

  logic [DATA_WIDTH-1:0] ram [0:2**ADDRESS_WIDTH-1];

  always_ff @(posedge clk) begin
    if (we) begin
      ram[wr_addr] <= wdata;
    end
  end

  // Registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    rdata <= ram[rd_addr];
  end

endmodule

//--- ppfifo.sv
`timescale 1ns/10ps
`include "test_mem_macros.svh"

module ppfifo #(
  parameter int ADDRESS_WIDTH = `TM_FIFO_AW
) (
  input  logic                      clk,
  input  logic                      rst,

  output logic [1:0]                write_ready,
  input  logic [1:0]                write_activate,
  output test_mem_pkg::xfer_count_t write_fifo_size,
  input  logic                      write_strobe,
  input  test_mem_pkg::data_word_t  write_data,
  output logic                      starved,

  input  logic                      read_strobe,
  output logic                      read_ready,
  input  logic                      read_activate,
  output test_mem_pkg::xfer_count_t read_count,
  output test_mem_pkg::data_word_t  read_data
);
  import test_mem_pkg::*;

  localparam int DEPTH = 2 ** ADDRESS_WIDTH;

  // Both buffers share one array, buffer select is the top index bit
  data_word_t               buf_mem [0:2*DEPTH-1];
  xfer_count_t              fill [2];
  logic [1:0]               committed;
  logic [1:0]               wr_active_q;
  logic                     rd_active_q;
  logic                     rd_sel;
  logic [ADDRESS_WIDTH-1:0] rd_ptr;
  logic                     live;
  logic                     wr_sel;
  logic                     wr_en;

  assign write_fifo_size = xfer_count_t'(DEPTH);

  assign wr_sel = write_activate[1];
  assign wr_en  = write_strobe && (write_activate != 2'b00) &&
                  (fill[wr_sel] < write_fifo_size);

  // Free means neither held by the writer nor waiting for the reader
  assign write_ready[0] = live && !committed[0] && !wr_active_q[0];
  assign write_ready[1] = live && !committed[1] && !wr_active_q[1];

  assign read_ready = committed[rd_sel] && !rd_active_q;
  assign read_count = fill[rd_sel];
  assign read_data  = buf_mem[{rd_sel, rd_ptr}];

  assign starved = (committed == 2'b00) && (fill[0] == '0) && (fill[1] == '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      buf_mem[{wr_sel, fill[wr_sel][ADDRESS_WIDTH-1:0]}] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      live        <= 1'b0;
      committed   <= 2'b00;
      wr_active_q <= 2'b00;
      rd_active_q <= 1'b0;
      rd_sel      <= 1'b0;
      rd_ptr      <= '0;
      fill[0]     <= '0;
      fill[1]     <= '0;
    end else begin
      live        <= 1'b1;
      wr_active_q <= write_activate;
      rd_active_q <= read_activate;

      if (wr_en) begin
        fill[wr_sel] <= fill[wr_sel] + 1'b1;
      end

      // Falling activate commits, an empty buffer just goes back to free
      for (int i = 0; i < 2; i++) begin
        if (wr_active_q[i] && !write_activate[i] && (fill[i] != '0)) begin
          committed[i] <= 1'b1;
          if (!committed[1 - i]) begin
            rd_sel <= (i == 1);
          end
        end
      end

      if (read_activate && read_strobe) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // Reader done with this buffer, the other one is next in order
      if (rd_active_q && !read_activate) begin
        committed[rd_sel] <= 1'b0;
        fill[rd_sel]      <= '0;
        rd_ptr            <= '0;
        rd_sel            <= !rd_sel;
      end
    end
  end

  a_single_writer: assert property (
    @(posedge clk) disable iff (rst) !(write_activate[0] && write_activate[1])
  );

  a_strobe_needs_activate: assert property (
    @(posedge clk) disable iff (rst) read_strobe |-> read_activate
  );

endmodule

//--- test_mem_ctrl.sv
`timescale 1ns/10ps
`include "test_mem_macros.svh"

module test_mem_ctrl #(
  parameter int ADDRESS_WIDTH = `TM_ADDR_WIDTH
) (
  input  logic                      clk,
  input  logic                      rst,

  input  test_mem_pkg::bram_req_t   bram,
  output test_mem_pkg::data_word_t  bram_rdata,
  output logic                      initializing,

  input  test_mem_pkg::xfer_cmd_t   write_cmd,
  input  logic                      write_enable,
  input  logic                      write_flush,
  output logic                      write_finished,
  output logic                      write_error,

  input  test_mem_pkg::xfer_cmd_t   read_cmd,
  input  logic                      read_enable,
  input  logic                      read_flush,
  output logic                      read_busy,
  output logic                      read_error,

  input  logic                      f2m_ready,
  output logic                      f2m_activate,
  input  test_mem_pkg::xfer_count_t f2m_size,
  output logic                      f2m_strobe,
  input  test_mem_pkg::data_word_t  f2m_data,
  input  logic                      f2m_starved,

  input  logic [1:0]                m2f_ready,
  output logic [1:0]                m2f_activate,
  input  test_mem_pkg::xfer_count_t m2f_size,
  output logic                      m2f_strobe,

  output logic                      mem_we,
  output logic [ADDRESS_WIDTH-1:0]  mem_wr_addr,
  output logic [ADDRESS_WIDTH-1:0]  mem_rd_addr,
  output test_mem_pkg::data_word_t  mem_wdata,
  input  test_mem_pkg::data_word_t  mem_rdata
);
  import test_mem_pkg::*;

  typedef logic [ADDRESS_WIDTH-1:0] addr_t;

  localparam data_word_t TOP_VALUE = data_word_t'(2 ** ADDRESS_WIDTH - 1);

  addr_t       fill_addr;
  logic        fill_done;

  logic        write_enable_q;
  addr_t       wr_addr;
  logic        wr_inc;
  logic        wr_dec;
  xfer_count_t wr_target;
  xfer_count_t wr_stored;
  xfer_count_t f2m_pos;
  logic        wr_first;
  logic        wr_have_prev;
  data_word_t  wr_prev;
  logic        wr_go;

  logic        read_enable_q;
  addr_t       rd_addr;
  logic        rd_inc;
  logic        rd_dec;
  xfer_count_t rd_target;
  xfer_count_t rd_issued;
  xfer_count_t m2f_pos;
  logic        rd_have_prev;
  data_word_t  rd_prev;
  logic        rd_go;

  // Counting pattern, wrapping at the top of the RAM
  function automatic logic follows(data_word_t prev, data_word_t word);
    return (word == prev + 1'b1) || ((prev == TOP_VALUE) && (word == '0));
  endfunction

  function automatic addr_t step(addr_t addr, logic inc, logic dec);
    if (inc) begin
      return addr + 1'b1;
    end
    if (dec) begin
      return addr - 1'b1;
    end
    return addr;
  endfunction

  // Engines stall while the BRAM port owns the RAM
  assign wr_go = fill_done && !bram.en && f2m_activate && (f2m_pos < f2m_size);
  assign rd_go = fill_done && !bram.en && read_busy && (m2f_activate != 2'b00) &&
                 (rd_issued < rd_target) && (m2f_pos < m2f_size);

  assign f2m_strobe     = wr_go;
  assign write_finished = (wr_stored >= wr_target) && f2m_starved;

  assign mem_we      = bram.en ? bram.we : (initializing || wr_go);
  assign mem_wr_addr = bram.en ? bram.address[ADDRESS_WIDTH-1:0] :
                       (initializing ? fill_addr : wr_addr);
  assign mem_wdata   = bram.en ? bram.wdata :
                       (initializing ? data_word_t'(fill_addr) : f2m_data);
  assign mem_rd_addr = bram.en ? bram.address[ADDRESS_WIDTH-1:0] : rd_addr;
  assign bram_rdata  = mem_rdata;

  // Fill: address a gets value a
  always_ff @(posedge clk) begin
    if (rst) begin
      initializing <= 1'b0;
      fill_done    <= 1'b0;
      fill_addr    <= '0;
    end else if (!fill_done) begin
      initializing <= 1'b1;
      if (initializing && !bram.en) begin
        fill_addr <= fill_addr + 1'b1;
        if (&fill_addr) begin
          initializing <= 1'b0;
          fill_done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      write_enable_q <= 1'b0;
      f2m_activate   <= 1'b0;
      f2m_pos        <= '0;
      wr_addr        <= '0;
      wr_inc         <= 1'b0;
      wr_dec         <= 1'b0;
      wr_target      <= '0;
      wr_stored      <= '0;
      wr_first       <= 1'b0;
      wr_have_prev   <= 1'b0;
      write_error    <= 1'b0;
    end else begin
      write_enable_q <= write_enable;
      write_error    <= 1'b0;

      if (!f2m_activate && f2m_ready && fill_done) begin
        f2m_activate <= 1'b1;
        f2m_pos      <= '0;
        wr_first     <= 1'b1;
      end else if (f2m_activate && (f2m_pos >= f2m_size)) begin
        f2m_activate <= 1'b0;
      end

      if (wr_go) begin
        f2m_pos      <= f2m_pos + 1'b1;
        wr_first     <= 1'b0;
        wr_prev      <= f2m_data;
        wr_have_prev <= 1'b1;
        // A buffer may repeat the last word of the previous one
        if (wr_have_prev && !write_flush && !follows(wr_prev, f2m_data) &&
            !(wr_first && (f2m_data == wr_prev))) begin
          write_error <= 1'b1;
        end
      end

      if (write_enable && !write_enable_q) begin
        wr_addr      <= write_cmd.addr[ADDRESS_WIDTH-1:0];
        wr_inc       <= write_cmd.inc;
        wr_dec       <= write_cmd.dec;
        wr_target    <= write_cmd.count;
        wr_stored    <= '0;
        wr_have_prev <= 1'b0;
      end else if (wr_go) begin
        wr_addr   <= step(wr_addr, wr_inc, wr_dec);
        wr_stored <= wr_stored + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_enable_q <= 1'b0;
      read_busy     <= 1'b0;
      m2f_activate  <= 2'b00;
      m2f_pos       <= '0;
      m2f_strobe    <= 1'b0;
      rd_addr       <= '0;
      rd_inc        <= 1'b0;
      rd_dec        <= 1'b0;
      rd_target     <= '0;
      rd_issued     <= '0;
      rd_have_prev  <= 1'b0;
      read_error    <= 1'b0;
    end else begin
      read_enable_q <= read_enable;
      // RAM data lands in the FIFO one cycle after the read
      m2f_strobe    <= rd_go;
      read_error    <= 1'b0;

      if ((m2f_activate == 2'b00) && (m2f_ready != 2'b00) && read_busy &&
          (rd_issued < rd_target)) begin
        m2f_activate <= m2f_ready[0] ? 2'b01 : 2'b10;
        m2f_pos      <= '0;
      end else if ((m2f_activate != 2'b00) && !rd_go &&
                   ((m2f_pos >= m2f_size) || (rd_issued >= rd_target))) begin
        // Commit when full or when the transfer has issued everything
        m2f_activate <= 2'b00;
      end

      if (rd_go) begin
        m2f_pos   <= m2f_pos + 1'b1;
        rd_addr   <= step(rd_addr, rd_inc, rd_dec);
        rd_issued <= rd_issued + 1'b1;
      end

      if (m2f_strobe) begin
        rd_prev      <= mem_rdata;
        rd_have_prev <= 1'b1;
        if (rd_have_prev && !read_flush && !follows(rd_prev, mem_rdata)) begin
          read_error <= 1'b1;
        end
      end

      if (read_busy && (rd_issued >= rd_target) && (m2f_activate == 2'b00) &&
          !m2f_strobe) begin
        read_busy <= 1'b0;
      end

      if (read_enable && !read_enable_q) begin
        rd_addr      <= read_cmd.addr[ADDRESS_WIDTH-1:0];
        rd_inc       <= read_cmd.inc;
        rd_dec       <= read_cmd.dec;
        rd_target    <= read_cmd.count;
        rd_issued    <= '0;
        rd_have_prev <= 1'b0;
        read_busy    <= (read_cmd.count != '0);
      end
    end
  end

  a_write_dir: assert property (
    @(posedge clk) disable iff (rst)
    $rose(write_enable) |-> !(write_cmd.inc && write_cmd.dec)
  );

  a_read_dir: assert property (
    @(posedge clk) disable iff (rst)
    $rose(read_enable) |-> !(read_cmd.inc && read_cmd.dec)
  );

endmodule

//--- test_mem_dev.sv
`timescale 1ns/10ps
`include "test_mem_macros.svh"

module test_mem_dev #(
  parameter int ADDRESS_WIDTH   = `TM_ADDR_WIDTH,
  parameter int READ_FIFO_SIZE  = `TM_FIFO_AW,
  parameter int WRITE_FIFO_SIZE = `TM_FIFO_AW
) (
  input  logic                      clk,
  input  logic                      rst,

  input  test_mem_pkg::bram_req_t   bram,
  output test_mem_pkg::data_word_t  bram_rdata,
  output logic                      initializing,

  input  test_mem_pkg::xfer_cmd_t   write_cmd,
  input  logic                      write_enable,
  input  logic                      write_flush,
  output logic                      write_finished,
  output logic                      write_error,

  output logic [1:0]                write_ready,
  input  logic [1:0]                write_activate,
  output test_mem_pkg::xfer_count_t write_size,
  input  logic                      write_strobe,
  input  test_mem_pkg::data_word_t  write_data,

  input  test_mem_pkg::xfer_cmd_t   read_cmd,
  input  logic                      read_enable,
  input  logic                      read_flush,
  output logic                      read_busy,
  output logic                      read_error,

  output logic                      read_ready,
  input  logic                      read_activate,
  output test_mem_pkg::xfer_count_t read_size,
  output test_mem_pkg::data_word_t  read_data,
  input  logic                      read_strobe
);
  import test_mem_pkg::*;

  logic                     f2m_ready;
  logic                     f2m_activate;
  xfer_count_t              f2m_size;
  logic                     f2m_strobe;
  data_word_t               f2m_data;
  logic                     f2m_starved;

  logic [1:0]               m2f_ready;
  logic [1:0]               m2f_activate;
  xfer_count_t              m2f_size;
  logic                     m2f_strobe;

  logic                     mem_we;
  logic [ADDRESS_WIDTH-1:0] mem_wr_addr;
  logic [ADDRESS_WIDTH-1:0] mem_rd_addr;
  data_word_t               mem_wdata;
  data_word_t               mem_rdata;

  blk_mem #(
    .DATA_WIDTH    ($bits(data_word_t)),
    .ADDRESS_WIDTH (ADDRESS_WIDTH)
  ) mem (
    .clk     (clk),
    .we      (mem_we),
    .wr_addr (mem_wr_addr),
    .rd_addr (mem_rd_addr),
    .wdata   (mem_wdata),
    .rdata   (mem_rdata)
  );

  // Host to RAM
  ppfifo #(
    .ADDRESS_WIDTH (WRITE_FIFO_SIZE)
  ) fifo_to_mem (
    .clk             (clk),
    .rst             (rst),
    .write_ready     (write_ready),
    .write_activate  (write_activate),
    .write_fifo_size (write_size),
    .write_strobe    (write_strobe),
    .write_data      (write_data),
    .starved         (f2m_starved),
    .read_strobe     (f2m_strobe),
    .read_ready      (f2m_ready),
    .read_activate   (f2m_activate),
    .read_count      (f2m_size),
    .read_data       (f2m_data)
  );

  // RAM to host, fed straight from the RAM read port
  ppfifo #(
    .ADDRESS_WIDTH (READ_FIFO_SIZE)
  ) mem_to_fifo (
    .clk             (clk),
    .rst             (rst),
    .write_ready     (m2f_ready),
    .write_activate  (m2f_activate),
    .write_fifo_size (m2f_size),
    .write_strobe    (m2f_strobe),
    .write_data      (mem_rdata),
    .starved         (),
    .read_strobe     (read_strobe),
    .read_ready      (read_ready),
    .read_activate   (read_activate),
    .read_count      (read_size),
    .read_data       (read_data)
  );

  test_mem_ctrl #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH)
  ) ctrl (
    .clk            (clk),
    .rst            (rst),
    .bram           (bram),
    .bram_rdata     (bram_rdata),
    .initializing   (initializing),
    .write_cmd      (write_cmd),
    .write_enable   (write_enable),
    .write_flush    (write_flush),
    .write_finished (write_finished),
    .write_error    (write_error),
    .read_cmd       (read_cmd),
    .read_enable    (read_enable),
    .read_flush     (read_flush),
    .read_busy      (read_busy),
    .read_error     (read_error),
    .f2m_ready      (f2m_ready),
    .f2m_activate   (f2m_activate),
    .f2m_size       (f2m_size),
    .f2m_strobe     (f2m_strobe),
    .f2m_data       (f2m_data),
    .f2m_starved    (f2m_starved),
    .m2f_ready      (m2f_ready),
    .m2f_activate   (m2f_activate),
    .m2f_size       (m2f_size),
    .m2f_strobe     (m2f_strobe),
    .mem_we         (mem_we),
    .mem_wr_addr    (mem_wr_addr),
    .mem_rd_addr    (mem_rd_addr),
    .mem_wdata      (mem_wdata),
    .mem_rdata      (mem_rdata)
  );

endmodule

//--- tb_test_mem_dev.sv
`timescale 1ns/10ps
`include "test_mem_macros.svh"

module tb_test_mem_dev;
  import test_mem_pkg::*;

  localparam int ADDR_W      = `TM_ADDR_WIDTH;
  localparam int FIFO_AW     = `TM_FIFO_AW;
  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam data_word_t WORD_MASK = data_word_t'(2 ** ADDR_W - 1);
  localparam xfer_count_t BUF_WORDS = xfer_count_t'(2 ** FIFO_AW);

  logic        clk;
  logic        rst;
  bram_req_t   bram;
  data_word_t  bram_rdata;
  logic        initializing;
  xfer_cmd_t   write_cmd;
  logic        write_enable;
  logic        write_flush;
  logic        write_finished;
  logic        write_error;
  logic [1:0]  write_ready;
  logic [1:0]  write_activate;
  xfer_count_t write_size;
  logic        write_strobe;
  data_word_t  write_data;
  xfer_cmd_t   read_cmd;
  logic        read_enable;
  logic        read_flush;
  logic        read_busy;
  logic        read_error;
  logic        read_ready;
  logic        read_activate;
  xfer_count_t read_size;
  data_word_t  read_data;
  logic        read_strobe;

  // Commands from the data file
  logic [7:0]        op_q[$];
  logic [ADDR_W-1:0] addr_q[$];
  data_word_t        arg_q[$];
  logic [7:0]        dir_q[$];
  data_word_t        start_q[$];
  bit                err_q[$];

  int seed = 32'h14dbf62b;
  int limit_cycles = 0;
  bit wr_err_seen;
  bit rd_err_seen;

  test_mem_dev #(
    .ADDRESS_WIDTH   (ADDR_W),
    .READ_FIFO_SIZE  (FIFO_AW),
    .WRITE_FIFO_SIZE (FIFO_AW)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Watchdog sized from the file contents
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit_cycles);
    stop_with_failure();
  end

  task automatic check_word(input string name, input data_word_t seen, input data_word_t exp);
    if (seen !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, seen, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input bit seen, input bit exp);
    if (seen !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, seen, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input xfer_count_t seen,
                             input xfer_count_t exp);
    if (seen !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, seen, exp);
      stop_with_failure();
    end
  endtask

  function automatic int idle_gap();
    return $unsigned($random(seed)) % 4;
  endfunction

  // Advance one clock and sample the error pulses before new inputs go out
  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
    if (write_error === 1'b1) wr_err_seen = 1'b1;
    if (read_error === 1'b1) rd_err_seen = 1'b1;
  endtask

  task automatic load_commands();
    int fd;
    int code;
    int words;
    string line;
    logic [7:0] op_c;
    logic [7:0] dir_c;
    logic [31:0] addr_v;
    logic [31:0] arg_v;
    logic [31:0] start_v;
    int err_v;
    words = 0;
    fd = $fopen("test_mem_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open test_mem_input.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0) break;
      if (line.len() < 3 || line.getc(0) == "#") continue;
      code = $sscanf(line, "%c %h %h %c %h %d", op_c, addr_v, arg_v, dir_c, start_v, err_v);
      if (code != 6 || !(op_c inside {"B", "R", "W", "T"})) begin
        $display("Malformed command line in test_mem_input.txt: %s", line);
        stop_with_failure();
      end
      op_q.push_back(op_c);
      addr_q.push_back(addr_v[ADDR_W-1:0]);
      arg_q.push_back(arg_v);
      dir_q.push_back(dir_c);
      start_q.push_back(start_v);
      err_q.push_back(err_v != 0);
      words += (op_c inside {"W", "T"}) ? int'(arg_v) : 1;
    end
    $fclose(fd);
    limit_cycles = words * 20 + 2 ** ADDR_W + 2000;
  endtask

  task automatic write_bram(input logic [ADDR_W-1:0] addr, input data_word_t data);
    bram.en      = 1'b1;
    bram.we      = 1'b1;
    bram.address = 64'(addr);
    bram.wdata   = data;
    tick();
    bram = '0;
  endtask

  task automatic read_bram(input logic [ADDR_W-1:0] addr, output data_word_t data);
    bram.en      = 1'b1;
    bram.we      = 1'b0;
    bram.address = 64'(addr);
    tick();
    data = bram_rdata;
    bram = '0;
  endtask

  task automatic run_write_xfer(input logic [ADDR_W-1:0] addr, input int count,
                                input bit dec, input data_word_t start, input bit skip);
    data_word_t words[$];
    data_word_t value;
    data_word_t seen;
    logic [ADDR_W-1:0] a;
    int sent;
    int in_buf;
    value = start;
    // Counting words with one value left out halfway when an error is expected
    for (int i = 0; i < count; i++) begin
      if (skip && i == count / 2) value = value + 1'b1;
      words.push_back(value);
      value = value + 1'b1;
    end
    write_cmd.addr  = 64'(addr);
    write_cmd.count = xfer_count_t'(count);
    write_cmd.inc   = !dec;
    write_cmd.dec   = dec;
    wr_err_seen     = 1'b0;
    write_enable    = 1'b1;
    tick();
    sent = 0;
    while (sent < count) begin
      while (write_ready == 2'b00) tick();
      write_activate = write_ready[0] ? 2'b01 : 2'b10;
      in_buf = 0;
      while (sent < count && in_buf < int'(write_size)) begin
        write_strobe = 1'b1;
        write_data   = words[sent];
        tick();
        write_strobe = 1'b0;
        sent++;
        in_buf++;
        repeat (idle_gap()) tick();
      end
      write_activate = 2'b00;
      tick();
    end
    while (!write_finished) tick();
    write_enable = 1'b0;
    check_flag("write_error", wr_err_seen, skip);
    tick();
    for (int i = 0; i < count; i++) begin
      a = dec ? addr - ADDR_W'(i) : addr + ADDR_W'(i);
      read_bram(a, seen);
      check_word("bram_rdata", seen, words[i]);
    end
  endtask

  task automatic run_read_xfer(input logic [ADDR_W-1:0] addr, input int count,
                               input bit dec, input data_word_t start, input bit exp_err);
    data_word_t expect_q[$];
    int got;
    int size;
    for (int i = 0; i < count; i++) begin
      if (dec) expect_q.push_back((start - data_word_t'(i)) & WORD_MASK);
      else expect_q.push_back((start + data_word_t'(i)) & WORD_MASK);
    end
    read_cmd.addr  = 64'(addr);
    read_cmd.count = xfer_count_t'(count);
    read_cmd.inc   = !dec;
    read_cmd.dec   = dec;
    rd_err_seen    = 1'b0;
    read_enable    = 1'b1;
    tick();
    got = 0;
    while (got < count) begin
      while (!read_ready) tick();
      read_activate = 1'b1;
      tick();
      // A buffer is full unless the transfer ends in it
      size = (count - got < int'(BUF_WORDS)) ? count - got : int'(BUF_WORDS);
      check_count("read_size", read_size, xfer_count_t'(size));
      for (int k = 0; k < size; k++) begin
        check_word("read_data", read_data, expect_q[got]);
        read_strobe = 1'b1;
        tick();
        read_strobe = 1'b0;
        got++;
        repeat (idle_gap()) tick();
      end
      read_activate = 1'b0;
      tick();
    end
    while (read_busy) tick();
    read_enable = 1'b0;
    check_flag("read_error", rd_err_seen, exp_err);
    tick();
  endtask

  initial begin
    data_word_t word;
    rst            = 1'b1;
    bram           = '0;
    write_cmd      = '0;
    write_enable   = 1'b0;
    write_flush    = 1'b0;
    write_activate = 2'b00;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_cmd       = '0;
    read_enable    = 1'b0;
    read_flush     = 1'b0;
    read_activate  = 1'b0;
    read_strobe    = 1'b0;
    load_commands();

    repeat (4) tick();
    check_flag("initializing", initializing, 1'b0);
    check_flag("read_busy", read_busy, 1'b0);
    check_flag("write_ready[0]", write_ready[0], 1'b0);
    check_flag("write_ready[1]", write_ready[1], 1'b0);
    check_flag("read_ready", read_ready, 1'b0);
    check_flag("write_error", write_error, 1'b0);
    check_flag("read_error", read_error, 1'b0);
    rst = 1'b0;
    tick();
    check_flag("initializing", initializing, 1'b1);
    check_count("write_size", write_size, BUF_WORDS);
    while (initializing) tick();

    for (int n = 0; n < op_q.size(); n++) begin
      case (op_q[n])
        "B": write_bram(addr_q[n], arg_q[n]);
        "R": begin
          read_bram(addr_q[n], word);
          check_word("bram_rdata", word, arg_q[n]);
        end
        "W": run_write_xfer(addr_q[n], int'(arg_q[n]), dir_q[n] == "D", start_q[n], err_q[n]);
        default: run_read_xfer(addr_q[n], int'(arg_q[n]), dir_q[n] == "D", start_q[n],
                               err_q[n]);
      endcase
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- test_mem_input.txt
# op addr arg dir start err (hex except err; dir I up, D down, - none)
# B/R: arg is data written or expected; W/T: arg is the word count, start the first word
R 00 00000000 - 00000000 0
R 05 00000005 - 00000000 0
R 7f 0000007f - 00000000 0
R ff 000000ff - 00000000 0
B 40 deadbeef - 00000000 0
R 40 deadbeef - 00000000 0
B 41 12345678 - 00000000 0
R 41 12345678 - 00000000 0
R 42 00000042 - 00000000 0
T fd 00000006 I 000000fd 0
T 30 00000005 D 00000030 1
T 10 00000028 I 00000010 0
W 80 00000014 I 00000100 0
W f8 0000000c I 00000200 0
R 03 0000020b - 00000000 0
R f7 000000f7 - 00000000 0
W 60 00000010 I 00000300 1
W a0 00000008 D 00000400 0
R 99 00000407 - 00000000 0
R 9f 00000401 - 00000000 0
T 20 00000008 I 00000020 0
R 27 00000027 - 00000000 0

//--- project.f
+incdir+.
test_mem_pkg.sv
blk_mem.sv
ppfifo.sv
test_mem_ctrl.sv
test_mem_dev.sv
tb_test_mem_dev.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_test_mem_dev -f project.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log
